// ==== fraise_settings.svh ====
/* sizes, register map and timing counts of the inference controller
   included by the RTL blocks, the package and the testbench */
`ifndef FRAISE_SETTINGS_SVH
`define FRAISE_SETTINGS_SVH

// bus
`define FRAISE_DATA_W 32
`define FRAISE_ADDR_W 32
`define FRAISE_HOSTS_LOG2 1

// matrix and array
`define FRAISE_ROWS 4
`define FRAISE_RES_W 8
`define FRAISE_OBS_W 9
`define FRAISE_ARR_ADDR_W 8
`define FRAISE_RUN_CYCLES 255 // stochastic window length

// register map, byte addresses
`define FRAISE_REG_ON_OFF 32'h0000_0010
`define FRAISE_REG_OBS_1 32'h0000_0018
`define FRAISE_REG_OBS_2 32'h0000_001C
`define FRAISE_REG_LAUNCH 32'h0000_0020
`define FRAISE_REG_RES_VALID 32'h0000_0024
`define FRAISE_REG_RES 32'h0000_0028
`define FRAISE_REG_IRQ_EN 32'h0000_0030
`define FRAISE_REG_PRECISION 32'h0000_0034
`define FRAISE_REG_COMP_INSTR 32'h0000_0038
`define FRAISE_REG_COMP_REF 32'h0000_003C
`define FRAISE_REG_COMP_RESULT 32'h0000_0040
`define FRAISE_REG_COMP_BYPASS 32'h0000_0044

`endif

// ==== fraise_pkg.sv ====
/* bus, array control and comparator types shared by the controller blocks
   import it in a module body, or use scoped names in port lists */
`default_nettype none

`include "fraise_settings.svh"

package fraise_pkg;

    typedef struct packed {
        logic                            valid;
        logic [`FRAISE_HOSTS_LOG2-1:0]   host;
        logic [`FRAISE_ADDR_W-1:0]       addr;
        logic                            wen; // 1 for write
        logic [`FRAISE_DATA_W-1:0]       wdata;
        logic [`FRAISE_DATA_W/8-1:0]     ben;
    } bus_req_t;

    typedef struct packed {
        logic                            valid;
        logic [`FRAISE_HOSTS_LOG2-1:0]   host; // initiator of the request
        logic [`FRAISE_DATA_W-1:0]       data;
    } bus_resp_t;

    // one byte per matrix row
    typedef logic [`FRAISE_ROWS-1:0][`FRAISE_RES_W-1:0] res_vec_t;
    typedef logic [`FRAISE_ROWS-1:0][`FRAISE_OBS_W-1:0] obs_vec_t;

    typedef enum logic [7:0] {
        comp_none,
        comp_eq,
        comp_gt,
        comp_lt,
        comp_min,
        comp_max
    } comp_op_e;

    typedef struct packed {
        res_vec_t instr;
        res_vec_t reference;
        res_vec_t precision; // tolerance of eq only
        logic     bypass;    // irq without a decision
    } comp_cfg_t;

    typedef struct packed {
        logic                            wl;
        logic                            sl;
        logic                            read_8;
        logic                            run;
        logic [`FRAISE_ARR_ADDR_W-1:0]   addr_col;
        logic [`FRAISE_ARR_ADDR_W-1:0]   addr_row;
    } array_ctrl_t;

    typedef struct packed {
        logic launch;
        logic on; // keep inferring back to back
    } seq_cmd_t;

endpackage

`default_nettype wire

// ==== fraise_regs.sv ====
/* bus decode, configuration and status registers and the one-cycle response
   sits between the host bus and the sequencer and decision blocks */
`timescale 1ns/100ps
`default_nettype none

`include "fraise_settings.svh"

module fraise_regs (
    input  wire logic                    clk_i,
    input  wire logic                    counter_read_reset,
    input  fraise_pkg::bus_req_t         req_i,
    output logic                         ready_o,
    output fraise_pkg::bus_resp_t        resp_o,
    input  wire logic                    busy_i,
    input  wire logic                    done_i,
    input  fraise_pkg::res_vec_t         results_i,
    input  wire logic [`FRAISE_ROWS-1:0] decision_i,
    output fraise_pkg::seq_cmd_t         cmd_o,
    output fraise_pkg::obs_vec_t         obs_o,
    output fraise_pkg::comp_cfg_t        cfg_o,
    output logic                         irq_en_o,
    output logic                         res_valid_o
);
    import fraise_pkg::*;

    localparam int unsigned DATA_W = `FRAISE_DATA_W;

    logic                           accept;
    logic                           wr_en;
    logic [DATA_W-1:0]              wmask;
    logic [DATA_W-1:0]              wdata_m;
    logic [DATA_W-1:0]              rd_data;

    logic                           on_q;
    logic                           launch_q;
    logic [DATA_W-1:0]              obs1_q;
    logic [DATA_W-1:0]              obs2_q;
    logic                           res_valid_q;
    logic                           irq_en_q;
    logic                           bypass_q;
    res_vec_t                       prec_q;
    res_vec_t                       instr_q;
    res_vec_t                       ref_q;

    logic                           resp_valid_q;
    logic [`FRAISE_HOSTS_LOG2-1:0]  resp_host_q;
    logic [DATA_W-1:0]              resp_data_q;

    assign ready_o = ~busy_i;
    assign accept  = req_i.valid & ready_o;
    assign wr_en   = accept & req_i.wen;

    // widen the byte enables to a bit mask
    always_comb begin
        for (int b = 0; b < DATA_W / 8; b++) begin
            wmask[b*8 +: 8] = {8{req_i.ben[b]}};
        end
    end
    assign wdata_m = req_i.wdata & wmask; // disabled bytes land as zero

    always_comb begin
        case (req_i.addr)
            `FRAISE_REG_ON_OFF:      rd_data = DATA_W'(on_q);
            `FRAISE_REG_OBS_1:       rd_data = obs1_q;
            `FRAISE_REG_OBS_2:       rd_data = obs2_q;
            `FRAISE_REG_LAUNCH:      rd_data = DATA_W'(launch_q);
            `FRAISE_REG_RES_VALID:   rd_data = DATA_W'(res_valid_q);
            `FRAISE_REG_RES:         rd_data = results_i;
            `FRAISE_REG_IRQ_EN:      rd_data = DATA_W'(irq_en_q);
            `FRAISE_REG_PRECISION:   rd_data = prec_q;
            `FRAISE_REG_COMP_INSTR:  rd_data = instr_q;
            `FRAISE_REG_COMP_REF:    rd_data = ref_q;
            `FRAISE_REG_COMP_RESULT: rd_data = DATA_W'(decision_i);
            `FRAISE_REG_COMP_BYPASS: rd_data = DATA_W'(bypass_q);
            default:                 rd_data = '0; // unmapped
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (counter_read_reset) begin
            on_q         <= 1'b0;
            launch_q     <= 1'b0;
            obs1_q       <= '0;
            obs2_q       <= '0;
            res_valid_q  <= 1'b0;
            irq_en_q     <= 1'b0;
            bypass_q     <= 1'b0;
            prec_q       <= '0;
            instr_q      <= '0;
            ref_q        <= '0;
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= accept;
            if (busy_i) begin
                launch_q <= 1'b0; // sequencer has taken it
            end
            if (done_i) begin
                res_valid_q <= 1'b1;
            end else if (accept && !req_i.wen && req_i.addr == `FRAISE_REG_RES) begin
                res_valid_q <= 1'b0;
            end
            if (wr_en) begin
                case (req_i.addr)
                    `FRAISE_REG_ON_OFF:      on_q     <= wdata_m[0];
                    `FRAISE_REG_OBS_1:       obs1_q   <= wdata_m;
                    `FRAISE_REG_OBS_2:       obs2_q   <= wdata_m;
                    `FRAISE_REG_LAUNCH:      launch_q <= wdata_m[0];
                    `FRAISE_REG_IRQ_EN:      irq_en_q <= wdata_m[0];
                    `FRAISE_REG_PRECISION:   prec_q   <= wdata_m;
                    `FRAISE_REG_COMP_INSTR:  instr_q  <= wdata_m;
                    `FRAISE_REG_COMP_REF:    ref_q    <= wdata_m;
                    `FRAISE_REG_COMP_BYPASS: bypass_q <= wdata_m[0];
                    default: ; // read-only or unmapped
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            resp_host_q <= req_i.host;
            resp_data_q <= rd_data;
        end
    end

    assign resp_o = '{valid: resp_valid_q, host: resp_host_q, data: resp_data_q};

    // two observations per word, one in each half
    assign obs_o = {obs2_q[24:16], obs2_q[8:0], obs1_q[24:16], obs1_q[8:0]};

    assign cmd_o       = '{launch: launch_q, on: on_q};
    assign cfg_o       = '{instr: instr_q, reference: ref_q, precision: prec_q, bypass: bypass_q};
    assign irq_en_o    = irq_en_q;
    assign res_valid_o = res_valid_q;

    // every response cycle answers a request taken on the edge before
    a_one_resp_per_req: assert property (@(posedge clk_i) disable iff (counter_read_reset)
        resp_o.valid |-> $past(accept && !counter_read_reset));

endmodule

`default_nettype wire

// ==== fraise_sequencer.sv ====
/* inference FSM that reads the four observation rows and then counts the array
   output bits over the stochastic window into one result byte per row */
`timescale 1ns/100ps
`default_nettype none

`include "fraise_settings.svh"

module fraise_sequencer (
    input  wire logic                    clk_i,
    input  wire logic                    counter_read_reset,
    input  fraise_pkg::seq_cmd_t         cmd_i,
    input  fraise_pkg::obs_vec_t         obs_i,
    output logic                         busy_o,
    output logic                         done_o,
    output fraise_pkg::res_vec_t         results_o,
    output fraise_pkg::array_ctrl_t      array_ctrl_o,
    input  wire logic [`FRAISE_ROWS-1:0] bit_out_i
);
    import fraise_pkg::*;

    localparam int unsigned ROW_W      = $clog2(`FRAISE_ROWS);
    localparam int unsigned STEP_W     = $clog2(`FRAISE_RUN_CYCLES + 1);
    localparam int unsigned READ_STEPS = 4 * `FRAISE_ROWS; // 4 phases per row
    localparam int unsigned ADDR_W     = `FRAISE_ARR_ADDR_W;
    localparam int unsigned RES_W      = `FRAISE_RES_W;

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_run,
        st_done
    } seq_state_e;

    seq_state_e         state_q;
    logic [STEP_W-1:0]  step_q; // read phase index, then run cycle count
    res_vec_t           results_q;
    logic [ROW_W-1:0]   row;
    logic [1:0]         phase;

    assign row   = step_q[ROW_W+1:2];
    assign phase = step_q[1:0];

    always_ff @(posedge clk_i) begin
        if (counter_read_reset) begin
            state_q   <= st_idle;
            step_q    <= '0;
            results_q <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (cmd_i.launch || cmd_i.on) begin
                        state_q   <= st_read;
                        step_q    <= '0;
                        results_q <= '0; // fresh counts for every run
                    end
                end
                st_read: begin
                    if (step_q == STEP_W'(READ_STEPS - 1)) begin
                        state_q <= st_run;
                        step_q  <= '0;
                    end else begin
                        step_q <= step_q + 1'b1;
                    end
                end
                st_run: begin
                    for (int r = 0; r < `FRAISE_ROWS; r++) begin
                        results_q[r] <= results_q[r] + RES_W'(bit_out_i[r]);
                    end
                    if (step_q == STEP_W'(`FRAISE_RUN_CYCLES - 1)) begin
                        state_q <= st_done;
                        step_q  <= '0;
                    end else begin
                        step_q <= step_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= st_idle; // done lasts one cycle
                end
            endcase
        end
    end

    // word line / source line sequence per row
    always_comb begin
        array_ctrl_o = '0;
        if (state_q == st_read) begin
            array_ctrl_o.read_8   = 1'b1;
            array_ctrl_o.wl       = (phase != 2'd3); // wl falls in the last phase
            array_ctrl_o.sl       = (phase == 2'd0); // sl only with the rising wl
            array_ctrl_o.addr_col = {row, obs_i[row][2:0], 3'b000};
            array_ctrl_o.addr_row = ADDR_W'(obs_i[row][`FRAISE_OBS_W-1:3]);
        end
        array_ctrl_o.run = (state_q == st_run);
    end

    assign busy_o    = (state_q != st_idle);
    assign done_o    = (state_q == st_done);
    assign results_o = results_q;

    a_run_read_excl: assert property (@(posedge clk_i) disable iff (counter_read_reset)
        !(array_ctrl_o.run && array_ctrl_o.read_8));

endmodule

`default_nettype wire

// ==== fraise_decision.sv ====
/* per-row comparators and min/max pick over the four results
   holds the decision word and raises irq once results are valid */
`timescale 1ns/100ps
`default_nettype none

`include "fraise_settings.svh"

module fraise_decision (
    input  wire logic                    clk_i,
    input  wire logic                    counter_read_reset,
    input  fraise_pkg::comp_cfg_t        cfg_i,
    input  fraise_pkg::res_vec_t         results_i,
    input  wire logic                    res_valid_i,
    input  wire logic                    irq_en_i,
    output logic [`FRAISE_ROWS-1:0]      decision_o,
    output logic                         irq_o
);
    import fraise_pkg::*;

    localparam int unsigned ROWS  = `FRAISE_ROWS;
    localparam int unsigned RES_W = `FRAISE_RES_W;

    logic [ROWS-1:0] cmp_bits;
    logic [ROWS-1:0] is_min;
    logic [ROWS-1:0] is_max;
    logic [ROWS-1:0] decision_next;
    logic [ROWS-1:0] decision_q;
    logic            res_valid_d_q;
    logic            dec_valid_q; // decision_q belongs to the current results
    comp_op_e        op0;

    function automatic logic compare_one(input comp_op_e op,
                                         input logic [RES_W-1:0] a,
                                         input logic [RES_W-1:0] b,
                                         input logic [RES_W-1:0] prec);
        logic [RES_W-1:0] diff;
        diff = (a > b) ? a - b : b - a;
        case (op)
            comp_eq: return diff <= prec;
            comp_gt: return a > b;
            comp_lt: return a < b;
            default: return 1'b0;
        endcase
    endfunction

    always_comb begin
        for (int i = 0; i < ROWS; i++) begin
            cmp_bits[i] = compare_one(comp_op_e'(cfg_i.instr[i]), results_i[i],
                                      cfg_i.reference[i], cfg_i.precision[i]);
            is_min[i] = 1'b1;
            is_max[i] = 1'b1;
            for (int j = 0; j < ROWS; j++) begin
                if (j != i) begin
                    is_min[i] &= (results_i[i] < results_i[j]); // strict so ties lose
                    is_max[i] &= (results_i[i] > results_i[j]);
                end
            end
        end
    end

    assign op0 = comp_op_e'(cfg_i.instr[0]);

    always_comb begin
        case (op0)
            comp_min: decision_next = is_min;
            comp_max: decision_next = is_max;
            default:  decision_next = cmp_bits;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (counter_read_reset) begin
            res_valid_d_q <= 1'b0;
            dec_valid_q   <= 1'b0;
            decision_q    <= '0;
        end else begin
            res_valid_d_q <= res_valid_i;
            if (res_valid_i && !res_valid_d_q) begin
                decision_q  <= decision_next;
                dec_valid_q <= 1'b1;
            end else if (!res_valid_i) begin
                dec_valid_q <= 1'b0;
            end
        end
    end

    assign decision_o = decision_q;
    assign irq_o      = res_valid_i && irq_en_i && (cfg_i.bypass || (dec_valid_q && |decision_q));

    a_irq_needs_valid: assert property (@(posedge clk_i) disable iff (counter_read_reset)
        !res_valid_i |-> !irq_o);

endmodule

`default_nettype wire

// ==== fraise_top.sv ====
/* top of the inference array controller: host bus in, array control out
   register block beside the sequencer and the decision stage */
`timescale 1ns/100ps
`default_nettype none

`include "fraise_settings.svh"

module fraise_top (
    input  wire logic                    clk_i,
    input  wire logic                    counter_read_reset,
    input  fraise_pkg::bus_req_t         req_i,
    output logic                         ready_o,
    output fraise_pkg::bus_resp_t        resp_o,
    output logic                         irq_o,
    output fraise_pkg::array_ctrl_t      array_ctrl_o,
    input  wire logic [`FRAISE_ROWS-1:0] bit_out_i
);
    import fraise_pkg::*;

    seq_cmd_t               cmd;
    obs_vec_t               obs;
    comp_cfg_t              cfg;
    res_vec_t               results;
    logic                   irq_en;
    logic                   res_valid;
    logic                   busy;
    logic                   done;
    logic [`FRAISE_ROWS-1:0] decision;

    fraise_regs u_regs (
        .clk_i              (clk_i),
        .counter_read_reset (counter_read_reset),
        .req_i              (req_i),
        .ready_o            (ready_o),
        .resp_o             (resp_o),
        .busy_i             (busy),
        .done_i             (done),
        .results_i          (results),
        .decision_i         (decision),
        .cmd_o              (cmd),
        .obs_o              (obs),
        .cfg_o              (cfg),
        .irq_en_o           (irq_en),
        .res_valid_o        (res_valid)
    );

    fraise_sequencer u_sequencer (
        .clk_i              (clk_i),
        .counter_read_reset (counter_read_reset),
        .cmd_i              (cmd),
        .obs_i              (obs),
        .busy_o             (busy),
        .done_o             (done),
        .results_o          (results),
        .array_ctrl_o       (array_ctrl_o),
        .bit_out_i          (bit_out_i)
    );

    fraise_decision u_decision (
        .clk_i              (clk_i),
        .counter_read_reset (counter_read_reset),
        .cfg_i              (cfg),
        .results_i          (results),
        .res_valid_i        (res_valid),
        .irq_en_i           (irq_en),
        .decision_o         (decision),
        .irq_o              (irq_o)
    );

endmodule

`default_nettype wire

// ==== tb_fraise_clock.sv ====
/* clock and reset source of the testbench, 8 ns period
   reset is held high for the first eight rising edges */
`timescale 1ns/100ps
`default_nettype none

module tb_fraise_clock #(
    parameter int HALF_PERIOD_NS = 4,
    parameter int RESET_CYCLES   = 8
) (
    output logic clk_o,
    output logic counter_read_reset
);
    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    initial begin
        counter_read_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 counter_read_reset = 1'b0; // released just after an edge
    end

endmodule

`default_nettype wire

// ==== tb_fraise.sv ====
/* testbench of the inference controller that drives the host bus, models the array
   outputs and checks the DUT with concurrent assertions */
`timescale 1ns/100ps
`default_nettype none

`include "fraise_settings.svh"

module tb_fraise;
    import fraise_pkg::*;

    localparam int MAX_CYCLES = 6000; // seven inferences of about 300 cycles with wide margin
    localparam logic [31:0] ZERO_REGS [13] = '{
        `FRAISE_REG_ON_OFF, `FRAISE_REG_OBS_1, `FRAISE_REG_OBS_2, `FRAISE_REG_LAUNCH,
        `FRAISE_REG_RES_VALID, `FRAISE_REG_RES, `FRAISE_REG_IRQ_EN, `FRAISE_REG_PRECISION,
        `FRAISE_REG_COMP_INSTR, `FRAISE_REG_COMP_REF, `FRAISE_REG_COMP_RESULT,
        `FRAISE_REG_COMP_BYPASS, 32'h0000_004C
    };

    logic        clk;
    logic        counter_read_reset;
    bus_req_t    req = '0;
    logic        ready;
    bus_resp_t   resp;
    logic        irq;
    array_ctrl_t actrl;
    logic [3:0]  bit_out = '0;

    // expected values set by the stimulus and sampled by the assertions
    logic        chk_rd = 1'b0;
    logic [31:0] exp_rd = '0;
    logic        exp_host = 1'b0;
    logic        chk_irq = 1'b0;
    logic        exp_irq = 1'b0;
    array_ctrl_t exp_ctrl;
    res_vec_t    exp_cnt = '0;
    logic        launch_pend = 1'b0;
    logic        take_pend = 1'b0;
    int          since_launch = 0; // edges since the accepted launch write
    logic [31:0] obs_w1 = '0;
    logic [31:0] obs_w2 = '0;
    logic [31:0] cfg_instr = '0;
    logic [31:0] cfg_ref = '0;
    logic [31:0] cfg_prec = '0;
    logic        cfg_bypass = 1'b0;
    logic        cfg_irq_en = 1'b0;
    int          errors = 0;
    int          errors_at_start = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycles = 0;

    tb_fraise_clock u_clock (.clk_o(clk), .counter_read_reset(counter_read_reset));

    fraise_top DUT (
        .clk_i              (clk),
        .counter_read_reset (counter_read_reset),
        .req_i              (req),
        .ready_o            (ready),
        .resp_o             (resp),
        .irq_o              (irq),
        .array_ctrl_o       (actrl),
        .bit_out_i          (bit_out)
    );

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, want);
        errors++;
    endtask

    task automatic report_problem(input string what);
        $display("error at %0t: %s", $time, what);
        errors++;
    endtask

    // word line, source line and addresses of read step k
    function automatic array_ctrl_t expected_ctrl(input int k, input logic [31:0] o1,
                                                  input logic [31:0] o2);
        array_ctrl_t c;
        logic [8:0]  o;
        int          row;
        int          phase;
        row   = k / 4;
        phase = k % 4;
        case (row)
            0:       o = o1[8:0];
            1:       o = o1[24:16];
            2:       o = o2[8:0];
            default: o = o2[24:16];
        endcase
        c          = '0;
        c.read_8   = 1'b1;
        c.wl       = (phase != 3);
        c.sl       = (phase == 0);
        c.addr_col = {row[1:0], o[2:0], 3'b000};
        c.addr_row = {2'b00, o[8:3]};
        return c;
    endfunction

    function automatic logic [3:0] expected_decision(input res_vec_t cnt,
                                                     input logic [31:0] instr,
                                                     input logic [31:0] refw,
                                                     input logic [31:0] prec);
        logic [3:0] d;
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] op;
        d = '0;
        for (int i = 0; i < 4; i++) begin
            a  = cnt[i];
            b  = refw[i*8 +: 8];
            op = (instr[7:0] == comp_min || instr[7:0] == comp_max) ? instr[7:0] : instr[i*8 +: 8];
            case (op)
                comp_eq: d[i] = (((a > b) ? a - b : b - a) <= prec[i*8 +: 8]);
                comp_gt: d[i] = (a > b);
                comp_lt: d[i] = (a < b);
                comp_min, comp_max: begin
                    d[i] = 1'b1;
                    for (int j = 0; j < 4; j++) begin
                        if (j != i && (op == comp_min ? a >= cnt[j] : a <= cnt[j])) begin
                            d[i] = 1'b0; // a tie or a better row elsewhere
                        end
                    end
                end
                default: d[i] = 1'b0;
            endcase
        end
        return d;
    endfunction

    // one bus transfer that waits for ready and for the response cycle
    task automatic access_reg(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] ben, input logic [31:0] want);
        @(posedge clk);
        #1;
        exp_host  = ~exp_host;
        chk_rd    = !wr;
        exp_rd    = want;
        req.valid = 1'b1;
        req.host  = exp_host;
        req.addr  = addr;
        req.wen   = wr;
        req.wdata = wdata;
        req.ben   = ben;
        @(negedge clk);
        while (!ready) @(negedge clk);
        @(posedge clk);
        #1;
        req.valid = 1'b0;
        @(negedge clk);
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] ben);
        access_reg(1'b1, addr, data, ben, 32'h0);
    endtask

    task automatic read_reg(input logic [31:0] addr, input logic [31:0] want);
        access_reg(1'b0, addr, 32'h0, 4'h0, want);
    endtask

    task automatic set_compare(input logic [31:0] instr, input logic [31:0] refw,
                               input logic [31:0] prec, input logic bypass, input logic irq_en);
        cfg_instr  = instr;
        cfg_ref    = refw;
        cfg_prec   = prec;
        cfg_bypass = bypass;
        cfg_irq_en = irq_en;
        write_reg(`FRAISE_REG_COMP_INSTR, instr, 4'hf);
        write_reg(`FRAISE_REG_COMP_REF, refw, 4'hf);
        write_reg(`FRAISE_REG_PRECISION, prec, 4'hf);
        write_reg(`FRAISE_REG_COMP_BYPASS, 32'(bypass), 4'hf);
        write_reg(`FRAISE_REG_IRQ_EN, 32'(irq_en), 4'hf);
    endtask

    task automatic run_inference(input logic [31:0] obs1, input logic [31:0] obs2);
        logic [3:0] dec;
        obs_w1 = obs1;
        obs_w2 = obs2;
        write_reg(`FRAISE_REG_OBS_1, obs1, 4'hf);
        write_reg(`FRAISE_REG_OBS_2, obs2, 4'hf);
        read_reg(`FRAISE_REG_RES_VALID, 32'h0);
        chk_irq = 1'b0;
        write_reg(`FRAISE_REG_LAUNCH, 32'h1, 4'h1);
        read_reg(`FRAISE_REG_RES_VALID, 32'h1); // only accepted once busy ends
        dec = expected_decision(exp_cnt, cfg_instr, cfg_ref, cfg_prec);
        read_reg(`FRAISE_REG_COMP_RESULT, 32'(dec));
        exp_irq = cfg_irq_en && (cfg_bypass || dec != 4'h0);
        chk_irq = 1'b1;
        read_reg(`FRAISE_REG_RES, exp_cnt);
        exp_irq = 1'b0; // res_valid gone after the result read
        read_reg(`FRAISE_REG_RES_VALID, 32'h0);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d failed checks", tests_run, name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    // array model with rows biased apart so the min and max rows stand out
    always @(posedge clk) begin
        #1;
        for (int r = 0; r < 4; r++) begin
            bit_out[r] = ($urandom % 8) < 32'(r + 2);
        end
    end

    always @(negedge clk) begin
        take_pend   = req.valid && ready;
        launch_pend = take_pend && req.wen && req.addr == `FRAISE_REG_LAUNCH
                      && req.ben[0] && req.wdata[0];
        if (launch_pend) begin
            exp_cnt = '0;
        end else if (actrl.run) begin
            for (int r = 0; r < 4; r++) begin
                exp_cnt[r] = exp_cnt[r] + 8'(bit_out[r]);
            end
        end
    end

    always @(posedge clk) begin
        if (launch_pend) since_launch <= 1;
        else if (since_launch != 0 && since_launch < 300) since_launch <= since_launch + 1;
        else since_launch <= 0;
    end

    always_comb exp_ctrl = expected_ctrl(since_launch - 2, obs_w1, obs_w2);

    a_after_reset: assert property (@(posedge clk) $fell(counter_read_reset)
        |-> ready && !irq && !resp.valid && actrl == '0)
        else report_problem("DUT not idle after reset");
    a_resp_follows: assert property (@(posedge clk) disable iff (counter_read_reset)
        take_pend |=> resp.valid)
        else report_problem("no response in the cycle after an accepted request");
    a_resp_single: assert property (@(posedge clk) disable iff (counter_read_reset)
        resp.valid |=> !resp.valid)
        else report_problem("response valid held for two cycles");
    a_resp_host: assert property (@(posedge clk) disable iff (counter_read_reset)
        resp.valid |-> resp.host == exp_host)
        else report_mismatch("resp_o.host", 32'($sampled(resp.host)), 32'($sampled(exp_host)));
    a_resp_data: assert property (@(posedge clk) disable iff (counter_read_reset)
        resp.valid && chk_rd |-> resp.data == exp_rd)
        else report_mismatch("resp_o.data", $sampled(resp.data), $sampled(exp_rd));
    a_ready_busy: assert property (@(posedge clk) disable iff (counter_read_reset)
        since_launch >= 2 && since_launch <= 273 |-> !ready)
        else report_mismatch("ready_o", 32'h1, 32'h0);
    a_ready_back: assert property (@(posedge clk) disable iff (counter_read_reset)
        since_launch == 274 |-> ready)
        else report_mismatch("ready_o", 32'h0, 32'h1);
    a_read_phase: assert property (@(posedge clk) disable iff (counter_read_reset)
        since_launch >= 2 && since_launch <= 17 |-> actrl == exp_ctrl)
        else report_mismatch("array_ctrl_o", 32'($sampled(actrl)), 32'($sampled(exp_ctrl)));
    a_run_phase: assert property (@(posedge clk) disable iff (counter_read_reset)
        since_launch >= 18 && since_launch <= 272 |-> actrl.run && !actrl.read_8 && !actrl.wl)
        else report_problem("array control left the run phase inside the window");
    a_run_closed: assert property (@(posedge clk) disable iff (counter_read_reset)
        since_launch == 273 |-> !actrl.run)
        else report_mismatch("array_ctrl_o.run", 32'h1, 32'h0);
    a_irq_busy: assert property (@(posedge clk) disable iff (counter_read_reset)
        !ready |-> !irq)
        else report_mismatch("irq_o", 32'h1, 32'h0);
    a_irq_value: assert property (@(posedge clk) disable iff (counter_read_reset)
        chk_irq |-> irq == exp_irq)
        else report_mismatch("irq_o", 32'($sampled(irq)), 32'($sampled(exp_irq)));

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'ha5de_3477));
        @(negedge counter_read_reset);

        foreach (ZERO_REGS[i]) read_reg(ZERO_REGS[i], 32'h0);
        write_reg(`FRAISE_REG_PRECISION, 32'hdead_beef, 4'b0101);
        read_reg(`FRAISE_REG_PRECISION, 32'h00ad_00ef);
        write_reg(`FRAISE_REG_COMP_REF, 32'h1234_5678, 4'b1010);
        read_reg(`FRAISE_REG_COMP_REF, 32'h1200_5600);
        write_reg(`FRAISE_REG_OBS_2, 32'hffff_ffff, 4'b1100);
        read_reg(`FRAISE_REG_OBS_2, 32'hffff_0000);
        write_reg(`FRAISE_REG_IRQ_EN, 32'h1, 4'b0000);
        read_reg(`FRAISE_REG_IRQ_EN, 32'h0);
        write_reg(32'h0000_0050, 32'hffff_ffff, 4'hf); // unmapped
        read_reg(32'h0000_0050, 32'h0);
        end_test("registers after reset");

        set_compare(32'h0, 32'h0, 32'h0, 1'b0, 1'b0);
        run_inference(32'h00a5_0013, 32'h01ff_0088);
        end_test("launch and results");

        run_inference(32'h01ab_00c5, 32'h0017_01fe);
        end_test("array addressing");

        // rows 3..0 take lt, gt, eq, gt
        set_compare(32'h0302_0102, 32'h7864_6432, 32'h0000_2800, 1'b0, 1'b1);
        run_inference(32'h0101_0042, 32'h00f0_000f);
        end_test("comparators");

        set_compare(32'h0000_0005, 32'h0, 32'h0, 1'b0, 1'b1);
        run_inference(32'h0033_0144, 32'h0155_0066);
        set_compare(32'h0000_0004, 32'h0, 32'h0, 1'b0, 1'b1);
        run_inference(32'h0077_0188, 32'h0099_01aa);
        // bypass alone raises irq with an all-zero decision
        set_compare(32'h0, 32'h0, 32'h0, 1'b1, 1'b1);
        run_inference(32'h0021_0112, 32'h0134_0043);
        // irq stays low while disabled despite bypass and a decision
        set_compare(32'h0000_0005, 32'h0, 32'h0, 1'b1, 1'b0);
        run_inference(32'h0056_0165, 32'h0078_0187);
        end_test("min, max and irq");

        repeat (4) @(posedge clk);
        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
fraise_pkg.sv
fraise_regs.sv
fraise_sequencer.sv
fraise_decision.sv
fraise_top.sv
tb_fraise_clock.sv
tb_fraise.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and pass only on the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_fraise -f sources.f

out=$(./obj_dir/Vtb_fraise)
echo "$out"

if echo "$out" | grep -qx "NO ERRORS"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
